// File: run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_core -o tb_core_sim
./obj_dir/tb_core_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Some tests failed" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  exit 1
fi

// File: source/core_id_ex_stage.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// decode / execute stage
// decoder, immediates, ALU, branch and jump
// resolution, writeback select, LSU requests
//////////////////////////////////////////////////
`include "core_macros.svh"

module core_id_ex_stage (
  input  logic                    clk,
  input  logic                    reset_i,
  // from IF
  input  logic                    instr_valid_i,
  input  logic [`CORE_XLEN-1:0]   instr_rdata_i,
  input  logic [`CORE_XLEN-1:0]   pc_i,
  output logic                    id_ready_o,
  output logic                    pc_set_o,
  output logic [`CORE_XLEN-1:0]   jump_target_o,
  // register file
  output logic [`CORE_REG_AW-1:0] rf_raddr_a_o,
  output logic [`CORE_REG_AW-1:0] rf_raddr_b_o,
  input  logic [`CORE_XLEN-1:0]   rf_rdata_a_i,
  input  logic [`CORE_XLEN-1:0]   rf_rdata_b_i,
  output logic                    rf_we_o,
  output logic [`CORE_REG_AW-1:0] rf_waddr_o,
  output logic [`CORE_XLEN-1:0]   rf_wdata_o,
  // LSU
  output logic                    lsu_req_o,
  output logic                    lsu_we_o,
  output logic [`CORE_XLEN-1:0]   lsu_addr_o,
  output logic [`CORE_XLEN-1:0]   lsu_wdata_o,
  input  logic                    lsu_busy_i,
  input  logic                    lsu_rvalid_i,
  input  logic [`CORE_XLEN-1:0]   lsu_rdata_i
);
  import core_pkg::*;

  opcode_e                 opcode;
  alu_op_e                 alu_op;
  logic [2:0]              funct3;
  logic [`CORE_REG_AW-1:0] rd;
  logic [`CORE_XLEN-1:0]   imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [`CORE_XLEN-1:0]   alu_b, alu_result, wb_data;
  logic                    fire, lt, rd_we, branch_taken, load_wb;
  logic                    load_pending_q;  // lw waiting for its data
  logic [`CORE_REG_AW-1:0] load_rd_q;

  ////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////
  assign opcode = opcode_e'(instr_rdata_i[6:0]);
  assign funct3 = instr_rdata_i[14:12];
  assign rd     = instr_rdata_i[11:7];

  assign imm_i = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_b = {{20{instr_rdata_i[31]}}, instr_rdata_i[7], instr_rdata_i[30:25],
                  instr_rdata_i[11:8], 1'b0};
  assign imm_u = {instr_rdata_i[31:12], 12'b0};
  assign imm_j = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                  instr_rdata_i[30:21], 1'b0};

  assign rf_raddr_a_o = instr_rdata_i[19:15];  // rs1
  assign rf_raddr_b_o = instr_rdata_i[24:20];  // rs2

  // stall while a load or store is out on the data port
  assign id_ready_o = ~lsu_busy_i;
  assign fire       = instr_valid_i & id_ready_o;

  always_comb begin
    alu_op = ALU_ADD;                          // addi, and address math
    if (opcode == OPC_OP) begin
      case (funct3)
        3'b000:  alu_op = instr_rdata_i[30] ? ALU_SUB : ALU_ADD;
        3'b010:  alu_op = ALU_SLT;
        3'b100:  alu_op = ALU_XOR;
        3'b110:  alu_op = ALU_OR;
        3'b111:  alu_op = ALU_AND;
        default: alu_op = ALU_ADD;
      endcase
    end
  end

  ////////////////////////////////////////////////
  // execute
  ////////////////////////////////////////////////
  assign alu_b = (opcode == OPC_OP) ? rf_rdata_b_i : imm_i;
  assign lt    = $signed(rf_rdata_a_i) < $signed(alu_b);

  always_comb begin
    case (alu_op)
      ALU_SUB: alu_result = rf_rdata_a_i - alu_b;
      ALU_AND: alu_result = rf_rdata_a_i & alu_b;
      ALU_OR:  alu_result = rf_rdata_a_i | alu_b;
      ALU_XOR: alu_result = rf_rdata_a_i ^ alu_b;
      ALU_SLT: alu_result = {{(`CORE_XLEN-1){1'b0}}, lt};
      default: alu_result = rf_rdata_a_i + alu_b;
    endcase
  end

  // writeback select, unknown opcodes fall out as no-ops
  always_comb begin
    rd_we   = 1'b0;
    wb_data = alu_result;
    case (opcode)
      OPC_OP, OPC_OP_IMM: rd_we = 1'b1;
      OPC_LUI: begin
        rd_we   = 1'b1;
        wb_data = imm_u;
      end
      OPC_JAL: begin
        rd_we   = 1'b1;
        wb_data = pc_i + `CORE_XLEN'(4);    // link
      end
      default: rd_we = 1'b0;
    endcase
  end

  always_comb begin
    branch_taken = 1'b0;
    if (opcode == OPC_BRANCH) begin
      case (funct3)
        3'b000:  branch_taken = (rf_rdata_a_i == rf_rdata_b_i);  // beq
        3'b001:  branch_taken = (rf_rdata_a_i != rf_rdata_b_i);  // bne
        default: branch_taken = 1'b0;
      endcase
    end
  end

  assign pc_set_o      = fire & (branch_taken | (opcode == OPC_JAL));
  assign jump_target_o = pc_i + ((opcode == OPC_JAL) ? imm_j : imm_b);

  // one-cycle pulse toward the LSU
  assign lsu_req_o   = fire & ((opcode == OPC_LOAD) | (opcode == OPC_STORE));
  assign lsu_we_o    = (opcode == OPC_STORE);
  assign lsu_addr_o  = rf_rdata_a_i + (lsu_we_o ? imm_s : imm_i);
  assign lsu_wdata_o = rf_rdata_b_i;

  ////////////////////////////////////////////////
  // load writeback
  ////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i)
      load_pending_q <= 1'b0;
    else if (lsu_req_o)
      load_pending_q <= ~lsu_we_o;
    else if (lsu_rvalid_i)
      load_pending_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (lsu_req_o && !lsu_we_o)
      load_rd_q <= rd;
  end

  // never collides with ALU writes, id_ready is low during rvalid
  assign load_wb    = lsu_rvalid_i & load_pending_q;
  assign rf_we_o    = load_wb | (fire & rd_we);
  assign rf_waddr_o = load_wb ? load_rd_q : rd;
  assign rf_wdata_o = load_wb ? lsu_rdata_i : wb_data;

endmodule

// File: source/core_if_stage.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// instruction fetch stage
// fetch pc, req/gnt/rvalid request FSM and the
// one-entry instruction buffer toward ID/EX
//////////////////////////////////////////////////
`include "core_macros.svh"

module core_if_stage (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic [`CORE_XLEN-1:0] boot_addr_i,
  // instruction memory port
  output logic                  instr_req_o,
  output logic [`CORE_XLEN-1:0] instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [`CORE_XLEN-1:0] instr_rdata_i,
  // toward ID/EX
  output logic                  instr_valid_o,
  output logic [`CORE_XLEN-1:0] instr_rdata_o,
  output logic [`CORE_XLEN-1:0] pc_o,
  input  logic                  id_ready_i,
  input  logic                  pc_set_i,
  input  logic [`CORE_XLEN-1:0] jump_target_i
);
  import core_pkg::*;

  fetch_state_e          state_q, state_n;
  logic [`CORE_XLEN-1:0] fetch_pc_q, fetch_pc_n;  // address of next fetch
  logic [`CORE_XLEN-1:0] req_addr_q;              // held during address phase
  logic                  discard_q;               // in-flight fetch is stale
  logic                  buf_valid_q, buf_valid_n;
  logic [`CORE_XLEN-1:0] buf_rdata_q, buf_pc_q;
  logic                  consume, resp_done, resp_accept;

  assign consume     = buf_valid_q & id_ready_i;
  assign resp_done   = (state_q == FETCH_WAIT_RVALID) & instr_rvalid_i;
  assign resp_accept = resp_done & ~discard_q & ~pc_set_i;  // flushed data dropped

  always_comb begin
    fetch_pc_n = fetch_pc_q;
    if (pc_set_i)
      fetch_pc_n = jump_target_i;               // redirect
    else if (resp_accept)
      fetch_pc_n = fetch_pc_q + `CORE_XLEN'(4);
  end

  // buffer occupancy after this edge
  always_comb begin
    buf_valid_n = buf_valid_q;
    if (consume || pc_set_i)
      buf_valid_n = 1'b0;
    if (resp_accept)
      buf_valid_n = 1'b1;
  end

  // only request when the buffer is free, so a response always has a slot
  always_comb begin
    state_n = state_q;
    case (state_q)
      FETCH_IDLE:
        if (!buf_valid_n)
          state_n = FETCH_WAIT_GNT;
      FETCH_WAIT_GNT:
        if (instr_gnt_i)
          state_n = FETCH_WAIT_RVALID;
      FETCH_WAIT_RVALID:
        if (instr_rvalid_i)
          state_n = buf_valid_n ? FETCH_IDLE : FETCH_WAIT_GNT;
      default: state_n = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q     <= FETCH_IDLE;
      fetch_pc_q  <= boot_addr_i;
      discard_q   <= 1'b0;
      buf_valid_q <= 1'b0;
      buf_rdata_q <= `CORE_NOP;
    end else begin
      state_q     <= state_n;
      fetch_pc_q  <= fetch_pc_n;
      buf_valid_q <= buf_valid_n;
      if (resp_done)
        discard_q <= 1'b0;
      else if (pc_set_i && state_q != FETCH_IDLE)
        discard_q <= 1'b1;                      // fetch outstanding on old path
      if (pc_set_i)
        buf_rdata_q <= `CORE_NOP;
      else if (resp_accept)
        buf_rdata_q <= instr_rdata_i;
    end
  end

  // address and pc payload
  always_ff @(posedge clk) begin
    if (state_n == FETCH_WAIT_GNT && state_q != FETCH_WAIT_GNT)
      req_addr_q <= fetch_pc_n;
    if (resp_accept)
      buf_pc_q <= req_addr_q;
  end

  assign instr_req_o   = (state_q == FETCH_WAIT_GNT);
  assign instr_addr_o  = req_addr_q;
  assign instr_valid_o = buf_valid_q;
  assign instr_rdata_o = buf_rdata_q;
  assign pc_o          = buf_pc_q;

endmodule

// File: source/core_load_store_unit.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// load store unit
// latches one word request and runs it over the
// data req/gnt/rvalid port
//////////////////////////////////////////////////
`include "core_macros.svh"

module core_load_store_unit (
  input  logic                  clk,
  input  logic                  reset_i,
  // from ID/EX
  input  logic                  lsu_req_i,
  input  logic                  lsu_we_i,
  input  logic [`CORE_XLEN-1:0] lsu_addr_i,
  input  logic [`CORE_XLEN-1:0] lsu_wdata_i,
  output logic                  lsu_busy_o,
  output logic                  lsu_rvalid_o,
  output logic [`CORE_XLEN-1:0] lsu_rdata_o,
  // data memory port
  output logic                  data_req_o,
  output logic                  data_we_o,
  output logic [`CORE_XLEN-1:0] data_addr_o,
  output logic [`CORE_XLEN-1:0] data_wdata_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic [`CORE_XLEN-1:0] data_rdata_i
);
  import core_pkg::*;

  lsu_state_e            state_q;
  logic                  we_q;
  logic [`CORE_XLEN-1:0] addr_q, wdata_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= LSU_IDLE;
    end else begin
      case (state_q)
        LSU_IDLE:
          if (lsu_req_i)
            state_q <= LSU_WAIT_GNT;
        LSU_WAIT_GNT:
          if (data_gnt_i)
            state_q <= LSU_WAIT_RVALID;       // address phase done
        LSU_WAIT_RVALID:
          if (data_rvalid_i)
            state_q <= LSU_IDLE;
        default: state_q <= LSU_IDLE;
      endcase
    end
  end

  // request payload, held until the grant
  always_ff @(posedge clk) begin
    if (state_q == LSU_IDLE && lsu_req_i) begin
      we_q    <= lsu_we_i;
      addr_q  <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
  end

  assign data_req_o   = (state_q == LSU_WAIT_GNT);
  assign data_we_o    = data_req_o & we_q;     // only meaningful with req
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  assign lsu_busy_o   = (state_q != LSU_IDLE);
  assign lsu_rvalid_o = (state_q == LSU_WAIT_RVALID) & data_rvalid_i;
  assign lsu_rdata_o  = data_rdata_i;

endmodule

// File: source/core_macros.svh
//////////////////////////////////////////////////
// core wide constants
// data width, register file size, opcode field
// width and the NOP encoding
//////////////////////////////////////////////////
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define CORE_XLEN      32             // data and address width
`define CORE_NREGS     32             // x0..x31
`define CORE_REG_AW    5              // register address width
`define CORE_OPCODE_W  7              // instr[6:0]
`define CORE_NOP       32'h0000_0013  // addi x0, x0, 0

`endif

// File: source/core_pkg.sv
//////////////////////////////////////////////////
// core types
// opcode and ALU operation enums, plus the
// state encodings of the two bus FSMs
//////////////////////////////////////////////////
`include "core_macros.svh"

package core_pkg;

  // major opcodes of the supported RV32I subset
  typedef enum logic [`CORE_OPCODE_W-1:0] {
    OPC_OP     = 7'b0110011,  // add sub and or xor slt
    OPC_OP_IMM = 7'b0010011,  // addi only
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,  // lw
    OPC_STORE  = 7'b0100011,  // sw
    OPC_BRANCH = 7'b1100011,  // beq bne
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
  } alu_op_e;

  // instruction port FSM
  typedef enum logic [1:0] {
    FETCH_IDLE, FETCH_WAIT_GNT, FETCH_WAIT_RVALID
  } fetch_state_e;

  // data port FSM
  typedef enum logic [1:0] {
    LSU_IDLE, LSU_WAIT_GNT, LSU_WAIT_RVALID
  } lsu_state_e;

endpackage

// File: source/core_regfile.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// integer register file
// two combinational read ports, one write port
//////////////////////////////////////////////////
`include "core_macros.svh"

module core_regfile (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic [`CORE_REG_AW-1:0] raddr_a_i,
  input  logic [`CORE_REG_AW-1:0] raddr_b_i,
  output logic [`CORE_XLEN-1:0]   rdata_a_o,
  output logic [`CORE_XLEN-1:0]   rdata_b_o,
  input  logic                    we_i,
  input  logic [`CORE_REG_AW-1:0] waddr_i,
  input  logic [`CORE_XLEN-1:0]   wdata_i
);

  logic [`CORE_XLEN-1:0] regs_q [`CORE_NREGS];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < `CORE_NREGS; i++)
        regs_q[i] <= '0;
    end else if (we_i && waddr_i != '0) begin   // x0 not writable
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// File: source/core_top.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// core top level
// fetch, decode/execute, register file and LSU
//////////////////////////////////////////////////
`include "core_macros.svh"

module core_top (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic [`CORE_XLEN-1:0] boot_addr_i,
  // instruction memory
  output logic                  instr_req_o,
  output logic [`CORE_XLEN-1:0] instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [`CORE_XLEN-1:0] instr_rdata_i,
  // data memory
  output logic                  data_req_o,
  output logic                  data_we_o,
  output logic [`CORE_XLEN-1:0] data_addr_o,
  output logic [`CORE_XLEN-1:0] data_wdata_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic [`CORE_XLEN-1:0] data_rdata_i
);

  logic                    instr_valid, id_ready, pc_set;          // IF <-> ID/EX
  logic [`CORE_XLEN-1:0]   instr_rdata, pc_id, jump_target;
  logic [`CORE_REG_AW-1:0] rf_raddr_a, rf_raddr_b, rf_waddr;       // regfile
  logic [`CORE_XLEN-1:0]   rf_rdata_a, rf_rdata_b, rf_wdata;
  logic                    rf_we;
  logic                    lsu_req, lsu_we, lsu_busy, lsu_rvalid;  // ID/EX <-> LSU
  logic [`CORE_XLEN-1:0]   lsu_addr, lsu_wdata, lsu_rdata;

  core_if_stage if_stage0 (
    .clk            (clk),            .reset_i       (reset_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_valid_o  (instr_valid),    .instr_rdata_o (instr_rdata),
    .pc_o           (pc_id),          .id_ready_i    (id_ready),
    .pc_set_i       (pc_set),         .jump_target_i (jump_target)
  );

  core_id_ex_stage id_ex_stage0 (
    .clk            (clk),            .reset_i       (reset_i),
    .instr_valid_i  (instr_valid),    .instr_rdata_i (instr_rdata),
    .pc_i           (pc_id),          .id_ready_o    (id_ready),
    .pc_set_o       (pc_set),         .jump_target_o (jump_target),
    .rf_raddr_a_o   (rf_raddr_a),     .rf_raddr_b_o  (rf_raddr_b),
    .rf_rdata_a_i   (rf_rdata_a),     .rf_rdata_b_i  (rf_rdata_b),
    .rf_we_o        (rf_we),          .rf_waddr_o    (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .lsu_req_o      (lsu_req),        .lsu_we_o      (lsu_we),
    .lsu_addr_o     (lsu_addr),       .lsu_wdata_o   (lsu_wdata),
    .lsu_busy_i     (lsu_busy),       .lsu_rvalid_i  (lsu_rvalid),
    .lsu_rdata_i    (lsu_rdata)
  );

  core_regfile regfile0 (
    .clk            (clk),            .reset_i       (reset_i),
    .raddr_a_i      (rf_raddr_a),     .raddr_b_i     (rf_raddr_b),
    .rdata_a_o      (rf_rdata_a),     .rdata_b_o     (rf_rdata_b),
    .we_i           (rf_we),          .waddr_i       (rf_waddr),
    .wdata_i        (rf_wdata)
  );

  core_load_store_unit lsu0 (
    .clk            (clk),            .reset_i       (reset_i),
    .lsu_req_i      (lsu_req),        .lsu_we_i      (lsu_we),
    .lsu_addr_i     (lsu_addr),       .lsu_wdata_i   (lsu_wdata),
    .lsu_busy_o     (lsu_busy),       .lsu_rvalid_o  (lsu_rvalid),
    .lsu_rdata_o    (lsu_rdata),
    .data_req_o     (data_req_o),     .data_we_o     (data_we_o),
    .data_addr_o    (data_addr_o),    .data_wdata_o  (data_wdata_o),
    .data_gnt_i     (data_gnt_i),     .data_rvalid_i (data_rvalid_i),
    .data_rdata_i   (data_rdata_i)
  );

endmodule

// File: verif/core_properties.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// handshake assertions for both memory ports
// bound into core_top
//////////////////////////////////////////////////
`include "core_macros.svh"

module core_properties (
  input logic                  clk,
  input logic                  reset_i,
  input logic                  instr_req_o,
  input logic [`CORE_XLEN-1:0] instr_addr_o,
  input logic                  instr_gnt_i,
  input logic                  data_req_o,
  input logic                  data_we_o,
  input logic [`CORE_XLEN-1:0] data_addr_o,
  input logic [`CORE_XLEN-1:0] data_wdata_o,
  input logic                  data_gnt_i,
  input logic                  data_rvalid_i
);

  logic data_outstanding_q;  // granted, rvalid not yet seen

  always_ff @(posedge clk) begin
    if (reset_i)
      data_outstanding_q <= 1'b0;
    else if (data_req_o && data_gnt_i)
      data_outstanding_q <= 1'b1;
    else if (data_rvalid_i)
      data_outstanding_q <= 1'b0;
  end

  // address phase held until grant
  instr_hold_a: assert property (@(posedge clk) disable iff (reset_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instruction request dropped or changed before grant");

  data_hold_a: assert property (@(posedge clk) disable iff (reset_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o)
      && $stable(data_we_o) && $stable(data_wdata_o))
    else $error("data request dropped or changed before grant");

  // one outstanding data access at most
  data_single_a: assert property (@(posedge clk) disable iff (reset_i)
    $rose(data_req_o) |-> !data_outstanding_q)
    else $error("data request raised while a response is outstanding");

endmodule

bind core_top core_properties props0 (
  .clk(clk), .reset_i(reset_i),
  .instr_req_o(instr_req_o), .instr_addr_o(instr_addr_o), .instr_gnt_i(instr_gnt_i),
  .data_req_o(data_req_o), .data_we_o(data_we_o), .data_addr_o(data_addr_o),
  .data_wdata_o(data_wdata_o), .data_gnt_i(data_gnt_i), .data_rvalid_i(data_rvalid_i)
);

// File: verif/core_stimulus.txt
# P <instr word>, program from address 0 | D <addr> <word>, data preload
# T <test name> | S <addr> <data>, expected stores in order
P 06400093
P ff900113
P 123451b7
P 00208233
P 402082b3
P 0020f333
P 0030e3b3
P 00314433
P 001124b3
P 10102023
P 10202223
P 10302423
P 10402623
P 10502823
P 10602a23
P 10702c23
P 10802e23
P 12902023
P 04002503
P 001505b3
P 12b02223
P 00108463
P 12102423
P 00109463
P 12202623
P 0080066f
P 12102823
P 12c02a23
P 03700013
P 12002c23
P 0000006f
D 00000040 a5a50f0f
T arithmetic
S 00000100 00000064
S 00000104 fffffff9
S 00000108 12345000
S 0000010c 0000005d
S 00000110 0000006b
S 00000114 00000060
S 00000118 12345064
S 0000011c edcbaff9
S 00000120 00000001
T load_use
S 00000124 a5a50f73
T branches
S 0000012c fffffff9
T jal_link
S 00000134 00000068
T x0_write
S 00000138 00000000

// File: verif/tb_core.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// core testbench
// clock, reset, stimulus reader, memory models
// with random grants, store checker, timeout
//////////////////////////////////////////////////
`include "core_macros.svh"

module tb_core;

  localparam string STIM_FILE = "verif/core_stimulus.txt";
  localparam int    SEED      = 32'hba48;

  logic                  clk, reset_i;
  logic [`CORE_XLEN-1:0] boot_addr_i;
  logic                  instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [`CORE_XLEN-1:0] instr_addr_o, instr_rdata_i;
  logic                  data_req_o, data_we_o, data_gnt_i, data_rvalid_i;
  logic [`CORE_XLEN-1:0] data_addr_o, data_wdata_o, data_rdata_i;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];
  int          exp_test_q [$];   // owning test of each store
  string       test_name_q [$];
  int          test_errs [$];
  int          prog_len, cycle_limit, cycles, exp_idx, extra_stores;
  int          passed, failed;
  bit          load_ok;

  core_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;      // 100 ns period
  end

  //////////////////////////////////////////////////
  // stimulus and checking
  //////////////////////////////////////////////////
  task automatic load_stimulus();
    int          fd;
    string       line, tag, name;
    logic [31:0] a, b;
    fd = $fopen(STIM_FILE, "r");
    load_ok = (fd != 0);
    if (load_ok) begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%s", tag) < 1)
          continue;                // blank line
        if (tag == "P") begin
          void'($sscanf(line, "%s %h", tag, a));
          imem[prog_len] = a;
          prog_len++;
        end else if (tag == "D") begin
          void'($sscanf(line, "%s %h %h", tag, a, b));
          dmem[a[9:2]] = b;
        end else if (tag == "T") begin
          void'($sscanf(line, "%s %s", tag, name));
          test_name_q.push_back(name);
          test_errs.push_back(0);
        end else if (tag == "S") begin
          void'($sscanf(line, "%s %h %h", tag, a, b));
          exp_addr_q.push_back(a);
          exp_data_q.push_back(b);
          exp_test_q.push_back(test_name_q.size() - 1);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic report_test(input int t);
    if (test_errs[t] == 0) begin
      $display("test %s passed", test_name_q[t]);
      passed++;
    end else begin
      $display("test %s failed with %0d errors", test_name_q[t], test_errs[t]);
      failed++;
    end
  endtask

  // compare one granted store with the next expected pair
  task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
    int t;
    if (exp_idx >= exp_addr_q.size()) begin
      $display("unexpected store of %h to %h after the last expected store", data, addr);
      extra_stores++;
      return;
    end
    t = exp_test_q[exp_idx];
    if (addr != exp_addr_q[exp_idx]) begin
      $display("[FAIL] %s store address expected %h actual %h",
               test_name_q[t], exp_addr_q[exp_idx], addr);
      test_errs[t]++;
    end
    if (data != exp_data_q[exp_idx]) begin
      $display("[FAIL] %s store data expected %h actual %h",
               test_name_q[t], exp_data_q[exp_idx], data);
      test_errs[t]++;
    end
    exp_idx++;
    if (exp_idx == exp_addr_q.size() || exp_test_q[exp_idx] != t)
      report_test(t);              // last store of this test
  endtask

  //////////////////////////////////////////////////
  // memory models, inputs change 1 ns after rise
  //////////////////////////////////////////////////
  initial begin
    int          i_wait, d_wait;
    bit          i_count, d_count, i_due, d_due;
    logic [31:0] i_addr, d_addr;
    void'($urandom(SEED));       // fixed seed for grant delays
    forever begin
      @(posedge clk);
      #1;
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      data_gnt_i     = 1'b0;
      data_rvalid_i  = 1'b0;
      if (reset_i) begin
        i_count = 0;
        d_count = 0;
        i_due   = 0;
        d_due   = 0;
      end else begin
        if (i_due) begin           // rvalid one cycle after grant
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = imem[i_addr[9:2]];
          i_due          = 0;
        end else if (instr_req_o) begin
          if (!i_count) begin
            i_wait  = int'($urandom_range(3, 0));
            i_count = 1;
          end
          if (i_wait == 0) begin
            instr_gnt_i = 1'b1;
            i_addr      = instr_addr_o;
            i_due       = 1;
            i_count     = 0;
          end else
            i_wait--;
        end
        if (d_due) begin
          data_rvalid_i = 1'b1;
          data_rdata_i  = dmem[d_addr[9:2]];
          d_due         = 0;
        end else if (data_req_o) begin
          if (!d_count) begin
            d_wait  = int'($urandom_range(3, 0));
            d_count = 1;
          end
          if (d_wait == 0) begin
            data_gnt_i = 1'b1;
            d_addr     = data_addr_o;
            d_due      = 1;
            d_count    = 0;
            if (data_we_o) begin   // store lands at grant
              dmem[data_addr_o[9:2]] = data_wdata_o;
              check_store(data_addr_o, data_wdata_o);
            end
          end else
            d_wait--;
        end
      end
    end
  end

  // watchdog
  initial begin
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (cycle_limit == 0 || cycles <= cycle_limit);
    $display("timeout after %0d cycles, %0d of %0d expected stores seen",
             cycles, exp_idx, exp_addr_q.size());
    $display("Some tests failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    reset_i        = 1'b1;
    boot_addr_i    = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    cycle_limit    = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = (32'(i) << 22) | `CORE_NOP;   // addi x0 with address in imm
      dmem[i] = 32'hda7a_0000 | (32'(i) << 2);
    end
    load_stimulus();
    if (!load_ok) begin
      $display("stimulus file %s could not be opened", STIM_FILE);
      failed++;
    end else begin
      cycle_limit = prog_len * 40;
      repeat (2) @(posedge clk);
      #1 reset_i = 1'b0;
      while (exp_idx < exp_addr_q.size())
        @(posedge clk);
      repeat (20) @(posedge clk);  // room for stray stores
      // whole sequence under random grants
      if (extra_stores == 0 && failed == 0) begin
        $display("test full_sequence passed");
        passed++;
      end else begin
        $display("test full_sequence failed, %0d extra stores", extra_stores);
        failed++;
      end
    end
    $display("tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
    if (failed == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+source
source/core_pkg.sv
source/core_regfile.sv
source/core_if_stage.sv
source/core_id_ex_stage.sv
source/core_load_store_unit.sv
source/core_top.sv
verif/core_properties.sv
verif/tb_core.sv
